// File: logic/rgmii_rx_pkg.sv
/*
 * Shared types and constants for the RGMII receive front end.
 * The in-band status layout follows the usual RGMII idle coding: link in
 * bit 0, clock speed in bits 2:1, duplex in bit 3. The upper nibble of an
 * idle byte is not decoded.
 * The CRC residue is given in MSB-first register order.
 */
`default_nettype none

package rgmii_rx_pkg;

    // ----------------------------------------------------------
    // byte and status types
    // ----------------------------------------------------------
    typedef logic [7:0] byte_t;                 // one received octet

    // bit 0 upward: link, speed, duplex
    typedef struct packed {
        logic       full_duplex;                // 1 = full, 0 = half
        logic [1:0] speed;                      // 00 10Mb, 01 100Mb, 10 1Gb
        logic       link_up;                    // 1 = link up
    } inband_status_t;

    typedef struct packed {
        logic [3:0]     rsvd;                   // not decoded
        inband_status_t status;
    } inband_pad_t;

    // same octet, read as frame data or as idle status
    typedef union packed {
        byte_t       data;
        inband_pad_t inband;
    } rx_byte_u;

    // ----------------------------------------------------------
    // CRC-32 and counter constants
    // ----------------------------------------------------------
    localparam logic [31:0] CRC_POLY    = 32'hEDB88320;  // 802.3 poly, reflected
    localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;  // good-frame remainder

    localparam int CNT_W = 4;                   // byte counter width, saturates

endpackage

`default_nettype wire

// File: logic/rx_byte_if.sv
/*
 * Registered receive byte plus frame-phase flags.
 * Everything here is driven by the frame FSM in one clock domain;
 * CRC and output stage only read.
 */
`timescale 1ns/100ps
`default_nettype none

interface rx_byte_if;
    import rgmii_rx_pkg::*;

    rx_byte_u rx_byte;          // sampled octet, data or idle status
    logic     dv;               // registered data valid
    logic     err;              // registered error flag
    logic     in_payload;       // byte is past the preamble, dv high
    logic     frame_start;      // first byte of a frame in the register
    logic     frame_last_seen;  // dv just fell, previous byte was the last

    modport fsm_mp (output rx_byte, dv, err, in_payload, frame_start, frame_last_seen);

    modport crc_mp (input rx_byte, in_payload, frame_start);

    modport sink_mp (input rx_byte, dv, err, in_payload, frame_start, frame_last_seen);

endinterface

`default_nettype wire

// File: logic/rx_frame_fsm.sv
/*
 * Input register and frame phase tracking.
 * Expects SDR bytes already in the mac_rx_clk domain.
 * A frame starts on a rising edge of dv. If dv is already high when
 * reset ends, the first byte sampled after reset starts a frame.
 * Pin to interface latency is one cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module rx_frame_fsm (
    input  logic                mac_rx_clk,
    input  logic                reset_i,
    input  rgmii_rx_pkg::byte_t rx_data_i,
    input  logic                rx_dv_i,
    input  logic                rx_err_i,
    output logic                cnt_clear_o,
    output logic                cnt_en_o,
    input  logic                preamble_done_i,
    rx_byte_if.fsm_mp           byte_if
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_PRE  = 2'd1;   // stripping preamble + SFD
    localparam logic [1:0] ST_PAY  = 2'd2;   // payload and FCS

    logic [1:0] state_q;
    logic [1:0] state_nxt;
    logic       dv_rise;

    // pin dv high while registered dv is low
    assign dv_rise = rx_dv_i & ~byte_if.dv;

    // counter index tracks the byte now entering the register
    assign cnt_clear_o = dv_rise;
    assign cnt_en_o    = rx_dv_i;

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE: begin
                if (dv_rise) state_nxt = ST_PRE;
            end
            ST_PRE: begin
                if (!rx_dv_i) begin
                    state_nxt = ST_IDLE;            // runt frame dropped in preamble
                end else if (preamble_done_i) begin
                    state_nxt = ST_PAY;             // SFD sits in the register
                end
            end
            ST_PAY: begin
                if (!rx_dv_i) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // ----------------------------------------------------------
    // state and interface flags
    // ----------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            state_q                 <= ST_IDLE;
            byte_if.dv              <= 1'b0;
            byte_if.err             <= 1'b0;
            byte_if.in_payload      <= 1'b0;
            byte_if.frame_start     <= 1'b0;
            byte_if.frame_last_seen <= 1'b0;
        end else begin
            state_q                 <= state_nxt;
            byte_if.dv              <= rx_dv_i;
            byte_if.err             <= rx_err_i;
            byte_if.in_payload      <= (state_nxt == ST_PAY);   // implies dv
            byte_if.frame_start     <= dv_rise;
            byte_if.frame_last_seen <= ~rx_dv_i & byte_if.dv;   // falling dv
        end
    end

    // octet loaded every cycle
    always_ff @(posedge mac_rx_clk) begin
        byte_if.rx_byte.data <= rx_data_i;
    end

endmodule

`default_nettype wire

// File: logic/rx_byte_counter.sv
/*
 * Byte index within the current frame.
 * Saturates at the top of CNT_W, so PREAMBLE_LEN must stay in 2..15.
 * Clear wins over enable.
 */
`timescale 1ns/100ps
`default_nettype none

module rx_byte_counter #(
    parameter int unsigned PREAMBLE_LEN = 8     // bytes stripped, SFD included
) (
    input  logic mac_rx_clk,
    input  logic reset_i,
    input  logic clear_i,
    input  logic en_i,
    output logic preamble_done_o
);
    import rgmii_rx_pkg::*;

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;                        // first byte of frame is index 0
        end else if (en_i && (cnt_q != '1)) begin
            cnt_q <= cnt_q + 1'b1;              // hold at all ones
        end
    end

    // last preamble byte in the register, next one is payload
    assign preamble_done_o = (cnt_q == CNT_W'(PREAMBLE_LEN - 1));

endmodule

`default_nettype wire

// File: logic/rx_crc32_check.sv
/*
 * CRC-32 check over payload and FCS, one byte per clock, LSB first.
 * Register is preset on frame start and left as is after the frame;
 * crc_ok_o is only meaningful when the last FCS byte has been folded in.
 * No final inversion is applied, a good frame leaves the fixed residue.
 */
`timescale 1ns/100ps
`default_nettype none

module rx_crc32_check (
    input  logic      mac_rx_clk,
    input  logic      reset_i,
    rx_byte_if.crc_mp byte_if,
    output logic      crc_ok_o
);
    import rgmii_rx_pkg::*;

    logic [31:0] crc_q;     // reflected register, bit 0 shifts out first
    logic [31:0] crc_rev;   // same value in MSB-first order

    // ----------------------------------------------------------
    // one octet through the reflected LFSR
    // ----------------------------------------------------------
    function automatic logic [31:0] crc_step(input logic [31:0] crc_in, input byte_t d);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            crc_q <= '1;
        end else if (byte_if.frame_start) begin
            crc_q <= '1;                        // preset, preamble not folded
        end else if (byte_if.in_payload) begin
            crc_q <= crc_step(crc_q, byte_if.rx_byte.data);
        end
    end

    // ----------------------------------------------------------
    // residue compare
    // ----------------------------------------------------------
    // residue constant is kept MSB first, so mirror the register
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            crc_rev[i] = crc_q[31-i];
        end
    end

    assign crc_ok_o = (crc_rev == CRC_RESIDUE);   // comb from register

endmodule

`default_nettype wire

// File: logic/rx_stream_out.sv
/*
 * Output stream stage: one hold register, then the port registers.
 * Two cycles from interface byte to ports, flags aligned with the byte.
 * eof, crc_good and fr_err appear only on the last payload byte;
 * a frame that ends inside its preamble produces nothing.
 * status_o follows idle bytes received without error.
 */
`timescale 1ns/100ps
`default_nettype none

module rx_stream_out (
    input  logic                         mac_rx_clk,
    input  logic                         reset_i,
    rx_byte_if.sink_mp                   byte_if,
    input  logic                         crc_ok_i,
    output rgmii_rx_pkg::byte_t          mac_rx_data_o,
    output logic                         mac_rx_valid_o,
    output logic                         mac_rx_sof_o,
    output logic                         mac_rx_eof_o,
    output logic                         mac_rx_crc_good_o,
    output logic                         mac_rx_fr_err_o,
    output rgmii_rx_pkg::inband_status_t status_o
);
    import rgmii_rx_pkg::*;

    byte_t          hold_data;
    logic           hold_valid;     // held byte is payload
    logic           hold_first;     // held byte is first after preamble
    logic           err_sticky;     // some byte of this frame had err
    logic           frame_end;      // held byte is the last one
    inband_status_t status_hold;

    assign frame_end = hold_valid & byte_if.frame_last_seen;

    // ----------------------------------------------------------
    // hold stage
    // ----------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        hold_data <= byte_if.rx_byte.data;
    end

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            hold_valid  <= 1'b0;
            hold_first  <= 1'b0;
            err_sticky  <= 1'b0;
            status_hold <= '0;
        end else begin
            hold_valid <= byte_if.in_payload;
            hold_first <= byte_if.in_payload & ~hold_valid;   // payload rising
            if (byte_if.frame_start) begin
                err_sticky <= byte_if.err;                    // restart per frame
            end else if (byte_if.dv && byte_if.err) begin
                err_sticky <= 1'b1;
            end
            // idle byte carries PHY status
            if (!byte_if.dv && !byte_if.err) begin
                status_hold <= byte_if.rx_byte.inband.status;
            end
        end
    end

    // ----------------------------------------------------------
    // port registers
    // ----------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        mac_rx_data_o <= hold_data;
    end

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            mac_rx_valid_o    <= 1'b0;
            mac_rx_sof_o      <= 1'b0;
            mac_rx_eof_o      <= 1'b0;
            mac_rx_crc_good_o <= 1'b0;
            mac_rx_fr_err_o   <= 1'b0;
            status_o          <= '0;
        end else begin
            mac_rx_valid_o    <= hold_valid;
            mac_rx_sof_o      <= hold_first;
            mac_rx_eof_o      <= frame_end;
            mac_rx_crc_good_o <= frame_end & crc_ok_i;     // last FCS byte folded
            mac_rx_fr_err_o   <= frame_end & err_sticky;
            status_o          <= status_hold;
        end
    end

endmodule

`default_nettype wire

// File: logic/rgmii_rx_top.sv
/*
 * Receive side of a gigabit RGMII MAC front end.
 * Input is the SDR byte stream after the DDR capture, on mac_rx_clk.
 * No back-pressure; output lags the pins by exactly two clocks.
 * Preamble of PREAMBLE_LEN bytes (SFD included) is removed, the FCS is
 * passed on and checked.
 */
`timescale 1ns/100ps
`default_nettype none

module rgmii_rx_top #(
    parameter int unsigned PREAMBLE_LEN = 8
) (
    input  logic                         mac_rx_clk,
    input  logic                         reset_i,
    input  rgmii_rx_pkg::byte_t          rx_data_i,
    input  logic                         rx_dv_i,
    input  logic                         rx_err_i,
    output rgmii_rx_pkg::byte_t          mac_rx_data_o,
    output logic                         mac_rx_valid_o,
    output logic                         mac_rx_sof_o,
    output logic                         mac_rx_eof_o,
    output logic                         mac_rx_crc_good_o,
    output logic                         mac_rx_fr_err_o,
    output rgmii_rx_pkg::inband_status_t status_o
);

    logic cnt_clear;
    logic cnt_en;
    logic preamble_done;
    logic crc_ok;

    rx_byte_if rx_if ();        // registered byte and phase flags

    // ----------------------------------------------------------
    // input register and phase tracking
    // ----------------------------------------------------------
    rx_frame_fsm fsm0 (
        .mac_rx_clk      (mac_rx_clk),
        .reset_i         (reset_i),
        .rx_data_i       (rx_data_i),
        .rx_dv_i         (rx_dv_i),
        .rx_err_i        (rx_err_i),
        .cnt_clear_o     (cnt_clear),
        .cnt_en_o        (cnt_en),
        .preamble_done_i (preamble_done),
        .byte_if         (rx_if.fsm_mp)
    );

    rx_byte_counter #(
        .PREAMBLE_LEN (PREAMBLE_LEN)
    ) cnt0 (
        .mac_rx_clk      (mac_rx_clk),
        .reset_i         (reset_i),
        .clear_i         (cnt_clear),
        .en_i            (cnt_en),
        .preamble_done_o (preamble_done)
    );

    // ----------------------------------------------------------
    // FCS check and output stream
    // ----------------------------------------------------------
    rx_crc32_check crc0 (
        .mac_rx_clk (mac_rx_clk),
        .reset_i    (reset_i),
        .byte_if    (rx_if.crc_mp),
        .crc_ok_o   (crc_ok)
    );

    rx_stream_out out0 (
        .mac_rx_clk        (mac_rx_clk),
        .reset_i           (reset_i),
        .byte_if           (rx_if.sink_mp),
        .crc_ok_i          (crc_ok),
        .mac_rx_data_o     (mac_rx_data_o),
        .mac_rx_valid_o    (mac_rx_valid_o),
        .mac_rx_sof_o      (mac_rx_sof_o),
        .mac_rx_eof_o      (mac_rx_eof_o),
        .mac_rx_crc_good_o (mac_rx_crc_good_o),
        .mac_rx_fr_err_o   (mac_rx_fr_err_o),
        .status_o          (status_o)
    );

endmodule

`default_nettype wire

// File: dv/tb_rgmii_rx.sv
/*
 * Testbench for the RGMII receive front end, PREAMBLE_LEN = 8.
 * Stimulus and expected outputs come from dv/rx_frame_patterns.hex,
 * which is read relative to the project root, so run from there.
 * Expected fields of a word belong to that word's own byte, i.e. they
 * are checked two clocks after the DUT sampled it.
 * mac_rx_data_o is compared only where valid is expected high.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_rgmii_rx;
    import rgmii_rx_pkg::*;

    localparam int MAX_WORDS  = 256;
    localparam int CLK_PERIOD = 20;
    localparam int LATENCY    = 3;      // 1 loop step to the sample edge, 2 in the DUT

    logic           mac_rx_clk;
    logic           reset_i;
    byte_t          rx_data_i;
    logic           rx_dv_i;
    logic           rx_err_i;
    byte_t          mac_rx_data_o;
    logic           mac_rx_valid_o;
    logic           mac_rx_sof_o;
    logic           mac_rx_eof_o;
    logic           mac_rx_crc_good_o;
    logic           mac_rx_fr_err_o;
    inband_status_t status_o;
    logic [3:0]     status_bits;        // status_o as a plain nibble

    // T S F V DD X dd, see the pattern file
    logic [35:0] pat_mem [0:MAX_WORDS-1];
    int          num_words   = 0;
    int          check_count = 0;
    int          err_count   = 0;
    int          test_errs   = 0;
    int          cur_word    = 0;
    logic        loaded      = 1'b0;

    assign status_bits = status_o;

    rgmii_rx_top #(
        .PREAMBLE_LEN (8)
    ) dut0 (
        .mac_rx_clk        (mac_rx_clk),
        .reset_i           (reset_i),
        .rx_data_i         (rx_data_i),
        .rx_dv_i           (rx_dv_i),
        .rx_err_i          (rx_err_i),
        .mac_rx_data_o     (mac_rx_data_o),
        .mac_rx_valid_o    (mac_rx_valid_o),
        .mac_rx_sof_o      (mac_rx_sof_o),
        .mac_rx_eof_o      (mac_rx_eof_o),
        .mac_rx_crc_good_o (mac_rx_crc_good_o),
        .mac_rx_fr_err_o   (mac_rx_fr_err_o),
        .status_o          (status_o)
    );

    initial begin
        mac_rx_clk = 1'b0;
        forever #(CLK_PERIOD / 2) mac_rx_clk = ~mac_rx_clk;
    end

    // ----------------------------------------------------------
    // helpers
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            test_errs++;
            $display("FAILED %s word %0d: got %h, expected %h",
                     name, cur_word, actual, expected);
        end
    endtask

    task automatic drive_inputs(input logic [35:0] w);
        rx_dv_i   = w[8];
        rx_err_i  = w[9];
        rx_data_i = w[7:0];
    endtask

    task automatic check_outputs(input logic [35:0] w);
        check_value("mac_rx_valid_o", 32'(mac_rx_valid_o), 32'(w[20]));
        check_value("mac_rx_sof_o", 32'(mac_rx_sof_o), 32'(w[21]));
        check_value("mac_rx_eof_o", 32'(mac_rx_eof_o), 32'(w[22]));
        check_value("mac_rx_crc_good_o", 32'(mac_rx_crc_good_o), 32'(w[23]));
        check_value("mac_rx_fr_err_o", 32'(mac_rx_fr_err_o), 32'(w[24]));
        check_value("status_o", 32'(status_bits), 32'(w[31:28]));
        if (w[20]) begin
            check_value("mac_rx_data_o", 32'(mac_rx_data_o), 32'(w[19:12]));  // payload only
        end
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        reset_i   = 1'b1;
        rx_dv_i   = 1'b0;
        rx_err_i  = 1'b0;
        rx_data_i = '0;

        // test id 0 marks words the file did not fill
        for (int i = 0; i < MAX_WORDS; i++) begin
            pat_mem[i] = 36'(i);
        end
        $readmemh("dv/rx_frame_patterns.hex", pat_mem);
        while (num_words < MAX_WORDS && pat_mem[num_words][35:32] != 4'h0) begin
            num_words++;
        end
        loaded = 1'b1;

        if (num_words == 0) begin
            $display("no words could be read from dv/rx_frame_patterns.hex");
        end else begin
            repeat (2) @(posedge mac_rx_clk);
            #1 reset_i = 1'b0;
            for (int j = 0; j < num_words + LATENCY; j++) begin
                @(posedge mac_rx_clk);
                #1;
                if (j >= LATENCY) begin
                    cur_word = j - LATENCY;
                    check_outputs(pat_mem[cur_word]);
                    // last word of a test group
                    if (cur_word == num_words - 1 ||
                        pat_mem[cur_word + 1][35:32] != pat_mem[cur_word][35:32]) begin
                        $display("test %0d done, %0d mismatches",
                                 pat_mem[cur_word][35:32], test_errs);
                        test_errs = 0;
                    end
                end
                if (j < num_words) begin
                    drive_inputs(pat_mem[j]);
                end else begin
                    drive_inputs(36'h0);        // idle tail while the pipe drains
                end
            end
        end

        $display("checks: %0d ok, %0d wrong", check_count - err_count, err_count);
        if (err_count == 0 && num_words > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // ----------------------------------------------------------
    // watchdog, twice the pattern time plus 1 us
    // ----------------------------------------------------------
    initial begin
        wait (loaded);
        #(num_words * CLK_PERIOD * 2 + 1000);
        $display("timeout: the pattern run did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/rx_frame_patterns.hex
// word = T S F V DD X dd: T test id, S status_o, F fr_err, V {crc_good,eof,sof,valid},
// DD data out, X {err,dv} in, dd data in; outputs belong to this word's own byte
// 1: idle after reset, all flags and status low
100000000 100000000 100000000
// 2: good frame, payload "123456789", FCS CBF43926 sent LSB first
200000155 200000155 200000155 200000155 200000155 200000155 200000155 2000001D5
200331131 200132132 200133133 200134134 200135135 200136136 200137137 200138138 200139139
200126126 200139139 2001F41F4 200DCB1CB
200000000 200000000
// 3: same frame, last FCS byte flipped, no crc_good at eof
300000155 300000155 300000155 300000155 300000155 300000155 300000155 3000001D5
300331131 300132132 300133133 300134134 300135135 300136136 300137137 300138138 300139139
300126126 300139139 3001F41F4 3005CA1CA
300000000 300000000
// 4: err on payload byte 35, fr_err at eof; then a clean frame
400000155 400000155 400000155 400000155 400000155 400000155 400000155 4000001D5
400331131 400132132 400133133 400134134 400135335 400136136 400137137 400138138 400139139
400126126 400139139 4001F41F4 401DCB1CB
400000000 400000000
400000155 400000155 400000155 400000155 400000155 400000155 400000155 4000001D5
400331131 400132132 400133133 400134134 400135135 400136136 400137137 400138138 400139139
400126126 400139139 4001F41F4 400DCB1CB
400000000 400000000
// 5: idle status D (link up, 1 Gb, full duplex), idle byte with err is ignored
5D000000D 5D000000D 5D0000202 5D000000D
// 6: two frames, one idle cycle between them
6D0000155 6D0000155 6D0000155 6D0000155 6D0000155 6D0000155 6D0000155 6D00001D5
6D0331131 6D0132132 6D0133133 6D0134134 6D0135135 6D0136136 6D0137137 6D0138138 6D0139139
6D0126126 6D0139139 6D01F41F4 6D0DCB1CB
6D000000D
6D0000155 6D0000155 6D0000155 6D0000155 6D0000155 6D0000155 6D0000155 6D00001D5
6D0331131 6D0132132 6D0133133 6D0134134 6D0135135 6D0136136 6D0137137 6D0138138 6D0139139
6D0126126 6D0139139 6D01F41F4 6D0DCB1CB
6D000000D 6D000000D

// File: list.f
logic/rgmii_rx_pkg.sv
logic/rx_byte_if.sv
logic/rx_frame_fsm.sv
logic/rx_byte_counter.sv
logic/rx_crc32_check.sv
logic/rx_stream_out.sv
logic/rgmii_rx_top.sv
dv/tb_rgmii_rx.sv

// File: Makefile
# Verilator build and run of the RGMII receive testbench

TOP := tb_rgmii_rx

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f list.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then \
		echo "simulation reported a failure"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
